// File: source/io_defs.svh
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// ********************************************************************
// Bus geometry
// ********************************************************************
`define IO_AW 16
`define IO_DW 32

// Bank widths
`define GPIO_DATA_W 32
`define GPIO_BTN_W  5

// ********************************************************************
// Slave codes in address bits 15:8
// ********************************************************************
`define SLV_GPIO_DATA 8'h00
`define SLV_GPIO_BTN  8'h01

// ********************************************************************
// Register indices in address bits 5:2
// ********************************************************************
`define REG_IN   4'd0
`define REG_OUT  4'd1
`define REG_OE   4'd2
`define REG_INTE 4'd3
// Write one to clear
`define REG_INTS 4'd4
`define REG_CTRL 4'd5

`endif

// File: source/io_pkg.sv
`include "io_defs.svh"

package io_pkg;

   // ********************************************************************
   // Address views
   // ********************************************************************

   // Decoded view of a byte address
   typedef struct packed {
      logic [7:0] slv;
      logic [1:0] rsvd;
      logic [3:0] reg_idx;
      logic [1:0] byte_ofs;
   } io_addr_fields_t;

   // The same 16 bits as a raw address or split into fields
   typedef union packed {
      logic [`IO_AW-1:0] raw;
      io_addr_fields_t   f;
   } io_addr_u;

   // ********************************************************************
   // Wishbone request and response
   // ********************************************************************

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      io_addr_u          adr;
      logic [`IO_DW-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic              err;
      logic [`IO_DW-1:0] dat;
   } wb_rsp_t;

endpackage

// File: source/io_wb_decode.sv
`timescale 1ns/10ps

`include "io_defs.svh"

module io_wb_decode import io_pkg::*; (
   input  logic    i_clk,
   input  logic    i_rst_n,
   input  wb_req_t i_req,
   output wb_req_t o_req_data,
   output wb_req_t o_req_btn,
   input  wb_rsp_t i_rsp_data,
   input  wb_rsp_t i_rsp_btn,
   output wb_rsp_t o_rsp
);

   logic req_valid;
   logic sel_data;
   logic sel_btn;
   logic sel_none;
   logic err_q;

   // ********************************************************************
   // Slave select from the upper address byte
   // ********************************************************************
   assign req_valid = i_req.cyc & i_req.stb;
   assign sel_data  = (i_req.adr.f.slv == `SLV_GPIO_DATA);
   assign sel_btn   = (i_req.adr.f.slv == `SLV_GPIO_BTN);
   assign sel_none  = ~(sel_data | sel_btn);

   // Each bank only sees stb for its own accesses
   always_comb begin
      o_req_data     = i_req;
      o_req_data.stb = i_req.stb & sel_data;
      o_req_btn      = i_req;
      o_req_btn.stb  = i_req.stb & sel_btn;
   end

   // ********************************************************************
   // Error responder for unmapped slave codes
   // ********************************************************************

   // Err lasts one cycle and stays low while the master still holds stb
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req_valid & sel_none & ~err_q;
      end
   end

   // ********************************************************************
   // Response mux
   // ********************************************************************

   // Address is held through the response cycle, so the select is stable
   always_comb begin
      if (sel_data) begin
         o_rsp = i_rsp_data;
      end else if (sel_btn) begin
         o_rsp = i_rsp_btn;
      end else begin
         o_rsp     = '0;
         o_rsp.err = err_q;
      end
   end

endmodule

// File: source/gpio_bank.sv
`timescale 1ns/10ps

`include "io_defs.svh"

module gpio_bank import io_pkg::*; #(
   parameter int WIDTH = 32
) (
   input  logic             i_clk,
   input  logic             i_rst_n,
   input  wb_req_t          i_req,
   output wb_rsp_t          o_rsp,
   input  logic [WIDTH-1:0] i_gpio_in,
   output logic [WIDTH-1:0] o_gpio_out,
   output logic [WIDTH-1:0] o_gpio_oe,
   output logic             o_irq
);

   logic [WIDTH-1:0]  in_meta;
   logic [WIDTH-1:0]  in_sync;
   logic [WIDTH-1:0]  in_prev;
   logic [WIDTH-1:0]  rise;
   logic [WIDTH-1:0]  out_q;
   logic [WIDTH-1:0]  oe_q;
   logic [WIDTH-1:0]  inte_q;
   logic [WIDTH-1:0]  ints_q;
   logic [WIDTH-1:0]  ints_clr;
   logic [WIDTH-1:0]  wdat;
   logic              ctrl_ie_q;
   logic              ack_q;
   logic              req_new;
   logic              wr_en;
   logic [`IO_DW-1:0] rd_mux;
   logic [`IO_DW-1:0] rdat_q;

   // ********************************************************************
   // Pad input synchronizer and edge detect
   // ********************************************************************
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         in_meta <= '0;
         in_sync <= '0;
         in_prev <= '0;
      end else begin
         in_meta <= i_gpio_in;
         in_sync <= in_meta;
         in_prev <= in_sync;
      end
   end

   assign rise = in_sync & ~in_prev;

   // ********************************************************************
   // Bus slave
   // ********************************************************************

   // New request only when not already answering it
   assign req_new = i_req.cyc & i_req.stb & ~ack_q;
   assign wr_en   = req_new & i_req.we;
   assign wdat    = i_req.dat[WIDTH-1:0];

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_q     <= '0;
         oe_q      <= '0;
         inte_q    <= '0;
         ctrl_ie_q <= 1'b0;
      end else if (wr_en) begin
         case (i_req.adr.f.reg_idx)
            `REG_OUT:  out_q     <= wdat;
            `REG_OE:   oe_q      <= wdat;
            `REG_INTE: inte_q    <= wdat;
            `REG_CTRL: ctrl_ie_q <= i_req.dat[0];
            default:   ;
         endcase
      end
   end

   // A new edge in the same cycle wins over the clear
   assign ints_clr = (wr_en && i_req.adr.f.reg_idx == `REG_INTS) ? wdat : '0;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ints_q <= '0;
      end else begin
         ints_q <= (ints_q & ~ints_clr) | (rise & inte_q);
      end
   end

   // Read data is zero-extended and reserved indices read zero
   always_comb begin
      rd_mux = '0;
      case (i_req.adr.f.reg_idx)
         `REG_IN:   rd_mux[WIDTH-1:0] = in_sync;
         `REG_OUT:  rd_mux[WIDTH-1:0] = out_q;
         `REG_OE:   rd_mux[WIDTH-1:0] = oe_q;
         `REG_INTE: rd_mux[WIDTH-1:0] = inte_q;
         `REG_INTS: rd_mux[WIDTH-1:0] = ints_q;
         `REG_CTRL: rd_mux[0]         = ctrl_ie_q;
         default:   rd_mux            = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (req_new) begin
         rdat_q <= rd_mux;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req_new;
      end
   end

   always_comb begin
      o_rsp.ack = ack_q;
      o_rsp.err = 1'b0;
      o_rsp.dat = rdat_q;
   end

   // Pads and interrupt
   assign o_gpio_out = out_q;
   assign o_gpio_oe  = oe_q;
   assign o_irq      = ctrl_ie_q & (|ints_q);

endmodule

// File: source/io_subsys_top.sv
`timescale 1ns/10ps

`include "io_defs.svh"

module io_subsys_top import io_pkg::*; (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   input  wb_req_t                 i_wb,
   output wb_rsp_t                 o_wb,
   input  logic [`GPIO_DATA_W-1:0] i_gpio_data_in,
   output logic [`GPIO_DATA_W-1:0] o_gpio_data_out,
   output logic [`GPIO_DATA_W-1:0] o_gpio_data_oe,
   input  logic [`GPIO_BTN_W-1:0]  i_gpio_btn_in,
   output logic [`GPIO_BTN_W-1:0]  o_gpio_btn_out,
   output logic [`GPIO_BTN_W-1:0]  o_gpio_btn_oe,
   output logic                    o_irq
);

   wb_req_t req_data;
   wb_req_t req_btn;
   wb_rsp_t rsp_data;
   wb_rsp_t rsp_btn;
   logic    irq_data;
   logic    irq_btn;

   // ********************************************************************
   // Address decoder
   // ********************************************************************
   io_wb_decode u_decode (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_req      (i_wb),
      .o_req_data (req_data),
      .o_req_btn  (req_btn),
      .i_rsp_data (rsp_data),
      .i_rsp_btn  (rsp_btn),
      .o_rsp      (o_wb)
   );

   // ********************************************************************
   // GPIO banks
   // ********************************************************************

   // LEDs and switches
   gpio_bank #(
      .WIDTH (`GPIO_DATA_W)
   ) u_gpio_data (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_req      (req_data),
      .o_rsp      (rsp_data),
      .i_gpio_in  (i_gpio_data_in),
      .o_gpio_out (o_gpio_data_out),
      .o_gpio_oe  (o_gpio_data_oe),
      .o_irq      (irq_data)
   );

   // Push buttons
   gpio_bank #(
      .WIDTH (`GPIO_BTN_W)
   ) u_gpio_btn (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_req      (req_btn),
      .o_rsp      (rsp_btn),
      .i_gpio_in  (i_gpio_btn_in),
      .o_gpio_out (o_gpio_btn_out),
      .o_gpio_oe  (o_gpio_btn_oe),
      .o_irq      (irq_btn)
   );

   // Single interrupt line for both banks
   assign o_irq = irq_data | irq_btn;

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

endmodule

// File: sim/io_subsys_props.sv
`timescale 1ns/10ps

module io_subsys_props import io_pkg::*; (
   input logic    i_clk,
   input logic    i_rst_n,
   input wb_req_t i_wb,
   input wb_rsp_t i_rsp,
   input logic    i_irq
);

   logic req_act;
   logic rsp_act;
   int   fail_cnt = 0;

   assign req_act = i_wb.cyc & i_wb.stb;
   assign rsp_act = i_rsp.ack | i_rsp.err;

   // ********************************************************************
   // Bus handshake
   // ********************************************************************
   rsp_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $rose(req_act) |=> rsp_act)
      else begin
         fail_cnt++;
         $error("no response one cycle after a new request");
      end

   ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_rsp.ack && i_rsp.err))
      else begin
         fail_cnt++;
         $error("ack and err high together");
      end

   // Response is a single-cycle pulse
   rsp_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      rsp_act |=> !rsp_act)
      else begin
         fail_cnt++;
         $error("response high for two cycles");
      end

   // ********************************************************************
   // Reset
   // ********************************************************************
   irq_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_irq)
      else begin
         fail_cnt++;
         $error("interrupt high during reset");
      end

endmodule

bind io_subsys_top io_subsys_props u_props (
   .i_clk   (i_clk),
   .i_rst_n (i_rst_n),
   .i_wb    (i_wb),
   .i_rsp   (o_wb),
   .i_irq   (o_irq)
);

// File: sim/tb_io_subsys.sv
`timescale 1ns/10ps

`include "io_defs.svh"

module tb_io_subsys import io_pkg::*; ();

   localparam int BUS_TIMEOUT = 20;
   localparam int IRQ_TIMEOUT = 20;

   logic                    clk;
   logic                    rst_n;
   wb_req_t                 wb;
   wb_rsp_t                 rsp;
   logic [`GPIO_DATA_W-1:0] data_in;
   logic [`GPIO_DATA_W-1:0] data_out;
   logic [`GPIO_DATA_W-1:0] data_oe;
   logic [`GPIO_BTN_W-1:0]  btn_in;
   logic [`GPIO_BTN_W-1:0]  btn_out;
   logic [`GPIO_BTN_W-1:0]  btn_oe;
   logic                    irq;
   int                      seed = 32'he65f_f2ca;
   int                      errors = 0;
   int                      checks = 0;
   int                      bit_idx;
   int                      total;
   logic [31:0]             rdat;
   logic                    ack;
   logic                    err;
   logic [31:0]             val;
   logic [31:0]             bval;

   tb_clk_gen u_clk_gen (
      .o_clk (clk)
   );

   io_subsys_top i_io_subsys_top (
      .i_clk           (clk),
      .i_rst_n         (rst_n),
      .i_wb            (wb),
      .o_wb            (rsp),
      .i_gpio_data_in  (data_in),
      .o_gpio_data_out (data_out),
      .o_gpio_data_oe  (data_oe),
      .i_gpio_btn_in   (btn_in),
      .o_gpio_btn_out  (btn_out),
      .o_gpio_btn_oe   (btn_oe),
      .o_irq           (irq)
   );

   // ********************************************************************
   // Helpers
   // ********************************************************************

   // Slave code, two unused bits, register index, byte offset
   function automatic logic [15:0] reg_addr(input logic [7:0] slv, input logic [3:0] idx);
      return {slv, 2'b00, idx, 2'b00};
   endfunction

   task automatic expect_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("ERROR %s expected 0x%h actual 0x%h", name, exp, act);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic set_pads(input logic [31:0] dval, input logic [4:0] btn);
      @(negedge clk);
      data_in = dval;
      btn_in  = btn;
   endtask

   // One single transfer with the request held until ack or err
   task automatic run_access(input logic we, input logic [15:0] addr, input logic [31:0] wdat);
      io_addr_u a;
      int       n;
      a.raw = addr;
      @(negedge clk);
      wb.cyc = 1'b1;
      wb.stb = 1'b1;
      wb.we  = we;
      wb.adr = a;
      wb.dat = wdat;
      n = 0;
      @(negedge clk);
      while (!(rsp.ack || rsp.err) && n < BUS_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      ack  = rsp.ack;
      err  = rsp.err;
      rdat = rsp.dat;
      assert (ack || err) else begin
         errors++;
         $display("No response came from the bus for address 0x%h", addr);
      end
      wb.cyc = 1'b0;
      wb.stb = 1'b0;
      wb.we  = 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] slv, input logic [3:0] idx,
                            input logic [31:0] wdat);
      run_access(1'b1, reg_addr(slv, idx), wdat);
      expect_value("o_wb.ack", 32'h1, 32'(ack));
   endtask

   task automatic read_reg(input logic [7:0] slv, input logic [3:0] idx,
                           input logic [31:0] exp, input string name);
      run_access(1'b0, reg_addr(slv, idx), 32'h0);
      expect_value("o_wb.ack", 32'h1, 32'(ack));
      expect_value(name, exp, rdat);
   endtask

   task automatic wait_irq(input logic level);
      int n;
      n = 0;
      while (irq !== level && n < IRQ_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      assert (irq === level) else begin
         errors++;
         $display("o_irq did not reach %0d within %0d cycles", level, IRQ_TIMEOUT);
      end
   endtask

   task automatic drive_bank_pad(input logic is_btn, input logic [31:0] pval);
      if (is_btn) begin
         set_pads(32'h0, pval[4:0]);
      end else begin
         set_pads(pval, 5'h0);
      end
   endtask

   // Edge interrupt with the global enable set and then clear
   task automatic exercise_irq(input logic [7:0] slv, input int idx, input logic is_btn);
      logic [31:0] mask;
      mask = 32'h1 << idx;
      drive_bank_pad(is_btn, 32'h0);
      wait_cycles(3);
      write_reg(slv, `REG_INTS, 32'hffff_ffff);
      write_reg(slv, `REG_INTE, mask);
      write_reg(slv, `REG_CTRL, 32'h1);
      drive_bank_pad(is_btn, mask);
      wait_irq(1'b1);
      read_reg(slv, `REG_INTS, mask, "REG_INTS after edge");
      write_reg(slv, `REG_INTS, mask);
      expect_value("o_irq", 32'h0, 32'(irq));
      read_reg(slv, `REG_INTS, 32'h0, "REG_INTS after clear");
      write_reg(slv, `REG_CTRL, 32'h0);
      drive_bank_pad(is_btn, 32'h0);
      wait_cycles(3);
      drive_bank_pad(is_btn, mask);
      wait_cycles(4);
      read_reg(slv, `REG_INTS, mask, "REG_INTS with irq disabled");
      expect_value("o_irq", 32'h0, 32'(irq));
      write_reg(slv, `REG_INTS, mask);
      write_reg(slv, `REG_INTE, 32'h0);
      drive_bank_pad(is_btn, 32'h0);
   endtask

   // ********************************************************************
   // Stimulus
   // ********************************************************************
   initial begin
      rst_n   = 1'b0;
      wb      = '0;
      data_in = '0;
      btn_in  = '0;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;

      // Reset state
      expect_value("o_irq", 32'h0, 32'(irq));
      expect_value("o_gpio_data_out", 32'h0, data_out);
      expect_value("o_gpio_data_oe", 32'h0, data_oe);
      expect_value("o_gpio_btn_out", 32'h0, 32'(btn_out));
      expect_value("o_gpio_btn_oe", 32'h0, 32'(btn_oe));
      read_reg(`SLV_GPIO_DATA, `REG_OUT, 32'h0, "data REG_OUT");
      read_reg(`SLV_GPIO_DATA, `REG_CTRL, 32'h0, "data REG_CTRL");
      read_reg(`SLV_GPIO_BTN, `REG_OUT, 32'h0, "btn REG_OUT");
      read_reg(`SLV_GPIO_BTN, `REG_CTRL, 32'h0, "btn REG_CTRL");

      // Output and enable registers
      for (int i = 0; i < 4; i++) begin
         val = $random(seed);
         write_reg(`SLV_GPIO_DATA, `REG_OUT, val);
         read_reg(`SLV_GPIO_DATA, `REG_OUT, val, "data REG_OUT");
         expect_value("o_gpio_data_out", val, data_out);
         val = $random(seed);
         write_reg(`SLV_GPIO_DATA, `REG_OE, val);
         read_reg(`SLV_GPIO_DATA, `REG_OE, val, "data REG_OE");
         expect_value("o_gpio_data_oe", val, data_oe);
         val = $random(seed);
         write_reg(`SLV_GPIO_BTN, `REG_OUT, val);
         read_reg(`SLV_GPIO_BTN, `REG_OUT, {27'h0, val[4:0]}, "btn REG_OUT");
         expect_value("o_gpio_btn_out", {27'h0, val[4:0]}, 32'(btn_out));
         val = $random(seed);
         write_reg(`SLV_GPIO_BTN, `REG_OE, val);
         read_reg(`SLV_GPIO_BTN, `REG_OE, {27'h0, val[4:0]}, "btn REG_OE");
         expect_value("o_gpio_btn_oe", {27'h0, val[4:0]}, 32'(btn_oe));
      end

      // Synchronized pad inputs
      for (int i = 0; i < 4; i++) begin
         val  = $random(seed);
         bval = $random(seed);
         set_pads(val, bval[4:0]);
         wait_cycles(3);
         read_reg(`SLV_GPIO_DATA, `REG_IN, val, "data REG_IN");
         read_reg(`SLV_GPIO_BTN, `REG_IN, {27'h0, bval[4:0]}, "btn REG_IN");
      end

      // Interrupts on the LED/switch bank and then the button bank
      set_pads(32'h0, 5'h0);
      bit_idx = $unsigned($random(seed)) % 32;
      exercise_irq(`SLV_GPIO_DATA, bit_idx, 1'b0);
      bit_idx = $unsigned($random(seed)) % 5;
      exercise_irq(`SLV_GPIO_BTN, bit_idx, 1'b1);

      // Unmapped slave codes answer with err only
      run_access(1'b0, {8'h02, 8'h10}, 32'h0);
      expect_value("o_wb.err", 32'h1, 32'(err));
      expect_value("o_wb.ack", 32'h0, 32'(ack));
      run_access(1'b1, {8'ha5, 8'h04}, $random(seed));
      expect_value("o_wb.err", 32'h1, 32'(err));
      expect_value("o_wb.ack", 32'h0, 32'(ack));

      // Reserved indices inside a bank
      read_reg(`SLV_GPIO_DATA, 4'd9, 32'h0, "data reserved reg");
      read_reg(`SLV_GPIO_BTN, 4'd15, 32'h0, "btn reserved reg");
      wait_cycles(2);

      total = errors + i_io_subsys_top.u_props.fail_cnt;
      $display("Checks: %0d, data errors: %0d, assertion failures: %0d",
               checks, errors, i_io_subsys_top.u_props.fail_cnt);
      if (total == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: build.f
+incdir+source
source/io_pkg.sv
source/io_wb_decode.sv
source/gpio_bank.sv
source/io_subsys_top.sv
sim/tb_clk_gen.sv
sim/io_subsys_props.sv
sim/tb_io_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and search the output for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_io_subsys \
   || { echo "Build failed"; exit 1; }

out="$(./obj_dir/Vtb_io_subsys +verilator+error+limit+1000)"
echo "$out"
echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1
